//--- tb.f
+incdir+hdl
hdl/nandCmdPkg.sv
hdl/nandBusPkg.sv
hdl/pageReadSequencer.sv
hdl/statusResetSequencer.sv
hdl/caBusArbiter.sv
hdl/caLatchIssuer.sv
hdl/nandCaTop.sv
tb/nandCaTop_assertions.sv
tb/nandCaTop_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status 1 on a failing run
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module nandCaTop_tb \
    -f tb.f -o simv > sim.log 2>&1 \
    && ./obj_dir/simv >> sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0

//--- tb/nandCaTop_tb.sv
`timescale 1ns/1ps
`include "nand_settings.svh"

module nandCaTop_tb;

    localparam int NumTests   = 11;
    localparam int CycleLimit = NumTests * (10 + `BUSY_WAIT_CYCLES + 10) + 10;

    typedef struct packed {
        logic               cle;
        logic               ale;
        nandBusPkg::caByteT data;
        nandCmdPkg::waySelT ceN;
    } pinByteT;

    typedef struct packed {
        nandCmdPkg::hostCmdT cmd;
        logic [3:0]          expBytes;   // we strobes
        logic [1:0]          expDone;    // 0 none, 1 read, 2 status
    } testEntryT;

    logic                iSystemClock;
    logic                rUsePresetC;
    nandCmdPkg::hostCmdT cmd;
    logic                cmdValid;
    logic                cmdReady;
    logic                readDone;
    logic                statusDone;
    logic                cle;
    logic                ale;
    logic                we;
    nandBusPkg::caByteT  io;
    nandCmdPkg::waySelT  ceN;

    testEntryT   testTable [NumTests];
    pinByteT     expQ[$];
    pinByteT     gotQ[$];
    logic [15:0] lfsrState;
    logic        inFlight = 1'b0;
    int          cycleCount = 0;
    int          lastWeCycle = 0;
    int          doneCycle = 0;
    int          readDoneCount = 0;
    int          statusDoneCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;

    nandCaTop dut_i
    (
        .iSystemClock (iSystemClock),
        .rUsePresetC  (rUsePresetC),
        .cmd          (cmd),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .readDone     (readDone),
        .statusDone   (statusDone),
        .cle          (cle),
        .ale          (ale),
        .we           (we),
        .io           (io),
        .ceN          (ceN)
    );

    initial
    begin
        iSystemClock = 1'b0;
        forever #50 iSystemClock = ~iSystemClock;
    end

    always @(posedge iSystemClock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("timeout after %0d cycles with the test table unfinished", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    // pin monitor, sampled mid cycle
    always @(negedge iSystemClock)
    begin
        if (we)
        begin
            gotQ.push_back(pinByteT'{cle, ale, io, ceN});
            lastWeCycle = cycleCount;
        end
        if (readDone || statusDone)
            doneCycle = cycleCount;
        if (readDone)
            readDoneCount++;
        if (statusDone)
            statusDoneCount++;
        assert (!(inFlight && cmdReady))
        else
        begin
            $display("cmdReady rose before completion at cycle %0d", cycleCount);
            errorCount++;
        end
    end

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 16'hB400 : 16'h0000);   // galois taps
        end
        return value;
    endfunction

    function automatic nandCmdPkg::hostCmdT makeCmd(input nandCmdPkg::idT target,
                                                    input nandCmdPkg::opcodeT opcode,
                                                    input nandCmdPkg::idT source);
        nandCmdPkg::hostCmdT c;
        int                  wayIndex;
        c.opcode    = opcode;
        c.targetId  = target;
        c.sourceId  = source;
        wayIndex    = randomBits($clog2(`NUM_WAYS)) % `NUM_WAYS;
        c.waySelect = '0;
        c.waySelect[wayIndex] = 1'b1;
        c.colAddress = 16'(randomBits(16));
        c.rowAddress = 24'(randomBits(24));
        return c;
    endfunction

    function automatic void expectByte(input logic isAddr, input nandBusPkg::caByteT b,
                                       input nandCmdPkg::waySelT way);
        expQ.push_back(pinByteT'{!isAddr, isAddr, b, ~way});
    endfunction

    function automatic void buildExpected(input nandCmdPkg::hostCmdT c);
        logic       slc;
        logic       preset;
        logic [2:0] pageSel;
        slc     = c.sourceId[3];
        preset  = c.sourceId[4];
        pageSel = c.sourceId[2:0];
        expQ.delete();
        if (c.opcode[5:1] != 5'b00000)
            return;
        if (c.targetId == `TARGET_STATUS_RESET)
            expectByte(1'b0, c.opcode[0] ? 8'hFF : 8'h70, c.waySelect);
        else if (c.targetId == `TARGET_PAGE_READ)
        begin
            if (preset)
                expectByte(1'b0, slc ? 8'hC9 : 8'h26, c.waySelect);
            if (slc || (pageSel != 3'b000))
                expectByte(1'b0, (!preset && slc) ? 8'hA2 : {5'b00000, pageSel}, c.waySelect);
            expectByte(1'b0, 8'h00, c.waySelect);
            expectByte(1'b1, c.colAddress[7:0], c.waySelect);
            expectByte(1'b1, c.colAddress[15:8], c.waySelect);
            expectByte(1'b1, c.rowAddress[7:0], c.waySelect);
            expectByte(1'b1, c.rowAddress[15:8], c.waySelect);
            expectByte(1'b1, c.rowAddress[23:16], c.waySelect);
            expectByte(1'b0, c.opcode[0] ? 8'h32 : 8'h30, c.waySelect);
        end
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic runTest(input int t);
        int      errorsBefore;
        int      readBefore;
        int      statusBefore;
        pinByteT got;
        pinByteT exp;
        buildExpected(testTable[t].cmd);
        gotQ.delete();
        errorsBefore = errorCount;
        readBefore   = readDoneCount;
        statusBefore = statusDoneCount;
        cmd      = testTable[t].cmd;
        cmdValid = 1'b1;
        @(negedge iSystemClock);
        while (!cmdReady)
            @(negedge iSystemClock);
        @(posedge iSystemClock);   // accepted on this edge
        #1;
        cmdValid = 1'b0;
        inFlight = (testTable[t].expDone != 2'd0);
        if (inFlight)
        begin
            while (readDoneCount + statusDoneCount == readBefore + statusBefore)
                @(posedge iSystemClock);
        end
        else
            repeat (`BUSY_WAIT_CYCLES + 10) @(posedge iSystemClock);   // quiet window
        #1;
        inFlight = 1'b0;
        checkValue($sformatf("test %0d strobe count", t), 32'(gotQ.size()),
                   32'(testTable[t].expBytes));
        checkValue($sformatf("test %0d strobes vs byte list", t), 32'(gotQ.size()),
                   32'(expQ.size()));
        for (int i = 0; i < gotQ.size() && i < expQ.size(); i++)
        begin
            got = gotQ[i];
            exp = expQ[i];
            checkValue($sformatf("test %0d byte %0d cle", t, i), 32'(got.cle), 32'(exp.cle));
            checkValue($sformatf("test %0d byte %0d ale", t, i), 32'(got.ale), 32'(exp.ale));
            checkValue($sformatf("test %0d byte %0d io", t, i), 32'(got.data), 32'(exp.data));
            checkValue($sformatf("test %0d byte %0d ceN", t, i), 32'(got.ceN), 32'(exp.ceN));
        end
        checkValue($sformatf("test %0d readDone pulses", t), 32'(readDoneCount - readBefore),
                   32'(testTable[t].expDone == 2'd1));
        checkValue($sformatf("test %0d statusDone pulses", t),
                   32'(statusDoneCount - statusBefore), 32'(testTable[t].expDone == 2'd2));
        if (testTable[t].expDone != 2'd0)
            checkValue($sformatf("test %0d done delay", t), 32'(doneCycle - lastWeCycle),
                       32'(`BUSY_WAIT_CYCLES + 1));
        $display("test %0d %s", t, (errorCount == errorsBefore) ? "ok" : "failed");
    endtask

    initial
    begin
        rUsePresetC = 1'b1;
        cmd         = '0;
        cmdValid    = 1'b0;
        lfsrState   = 16'd40;
        testTable[0]  = '{makeCmd(`TARGET_PAGE_READ, 6'd0, 5'b00000), 4'd7, 2'd1};
        testTable[1]  = '{makeCmd(`TARGET_PAGE_READ, 6'd0, 5'b00011), 4'd8, 2'd1};
        testTable[2]  = '{makeCmd(`TARGET_PAGE_READ, 6'd0, 5'b01000), 4'd8, 2'd1};   // pSLC
        testTable[3]  = '{makeCmd(`TARGET_PAGE_READ, 6'd1, 5'b00000), 4'd7, 2'd1};   // multi-plane
        testTable[4]  = '{makeCmd(`TARGET_PAGE_READ, 6'd0, 5'b11010), 4'd9, 2'd1};   // SSR preset
        testTable[5]  = '{makeCmd(`TARGET_PAGE_READ, 6'd0, 5'b10000), 4'd8, 2'd1};
        testTable[6]  = '{makeCmd(`TARGET_PAGE_READ, 6'd1, 5'b10101), 4'd9, 2'd1};
        testTable[7]  = '{makeCmd(`TARGET_STATUS_RESET, 6'd0, 5'b00000), 4'd1, 2'd2};
        testTable[8]  = '{makeCmd(`TARGET_STATUS_RESET, 6'd1, 5'b00000), 4'd1, 2'd2};
        testTable[9]  = '{makeCmd(5'b01001, 6'd0, 5'b00000), 4'd0, 2'd0};            // no owner
        testTable[10] = '{makeCmd(`TARGET_PAGE_READ, 6'd0, 5'b00110), 4'd8, 2'd1};
        repeat (10) @(posedge iSystemClock);
        #1;
        rUsePresetC = 1'b0;
        for (int t = 0; t < NumTests; t++)
            runTest(t);
        $display("tests %0d, checks %0d, errors %0d", NumTests, checkCount, errorCount);
        if (errorCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- tb/nandCaTop_assertions.sv
`timescale 1ns/1ps

module nandCaTop_assertions
(
    input logic               iSystemClock,
    input logic               rUsePresetC,
    input logic               cle,
    input logic               ale,
    input logic               we,
    input nandCmdPkg::waySelT ceN,
    input logic               readGrant,
    input logic               statusGrant
);

    cleAleExclusive: assert property (@(posedge iSystemClock) disable iff (rUsePresetC)
        !(cle && ale))
        else $error("cle and ale high in the same cycle");

    // a strobe must reach some chip
    strobeHasChip: assert property (@(posedge iSystemClock) disable iff (rUsePresetC)
        !(we && (ceN == '1)))
        else $error("we strobe with every chip enable inactive");

    grantExclusive: assert property (@(posedge iSystemClock) disable iff (rUsePresetC)
        !(readGrant && statusGrant))
        else $error("both sequencers granted the bus");

endmodule

bind nandCaTop nandCaTop_assertions assertionsInst
(
    .iSystemClock (iSystemClock),
    .rUsePresetC  (rUsePresetC),
    .cle          (cle),
    .ale          (ale),
    .we           (we),
    .ceN          (ceN),
    .readGrant    (readGrant),
    .statusGrant  (statusGrant)
);

//--- hdl/nandCaTop.sv
`timescale 1ns/1ps

module nandCaTop
(
    input  logic                iSystemClock,
    input  logic                rUsePresetC,
    input  nandCmdPkg::hostCmdT cmd,
    input  logic                cmdValid,
    output logic                cmdReady,
    output logic                readDone,
    output logic                statusDone,
    output logic                cle,
    output logic                ale,
    output logic                we,
    output nandBusPkg::caByteT  io,
    output nandCmdPkg::waySelT  ceN
);

    logic               readIdle;
    logic               statusIdle;
    logic               cmdAccept;
    logic               readReq;
    logic               statusReq;
    logic               readGrant;
    logic               statusGrant;
    logic               readOwnerDone;
    logic               statusOwnerDone;
    logic               seqDone;
    nandBusPkg::caBeatT readBeat;
    nandBusPkg::caBeatT statusBeat;
    nandBusPkg::caBeatT busBeat;

    assign cmdReady  = readIdle && statusIdle;
    assign cmdAccept = cmdValid && cmdReady;   // sequencers only see accepted commands

    pageReadSequencer readSeqInst
    (
        .iSystemClock (iSystemClock),
        .rUsePresetC  (rUsePresetC),
        .cmd          (cmd),
        .cmdValid     (cmdAccept),
        .idle         (readIdle),
        .busReq       (readReq),
        .busGrant     (readGrant),
        .beat         (readBeat),
        .ownerDone    (readOwnerDone),
        .opDone       (readDone)
    );

    statusResetSequencer statusSeqInst
    (
        .iSystemClock (iSystemClock),
        .rUsePresetC  (rUsePresetC),
        .cmd          (cmd),
        .cmdValid     (cmdAccept),
        .idle         (statusIdle),
        .busReq       (statusReq),
        .busGrant     (statusGrant),
        .beat         (statusBeat),
        .ownerDone    (statusOwnerDone),
        .opDone       (statusDone)
    );

    caBusArbiter arbiterInst
    (
        .iSystemClock (iSystemClock),
        .rUsePresetC  (rUsePresetC),
        .readReq      (readReq),
        .statusReq    (statusReq),
        .readBeat     (readBeat),
        .statusBeat   (statusBeat),
        .readGrant    (readGrant),
        .statusGrant  (statusGrant),
        .busBeat      (busBeat),
        .seqDone      (seqDone),
        .readDone     (readOwnerDone),
        .statusDone   (statusOwnerDone)
    );

    caLatchIssuer issuerInst
    (
        .iSystemClock (iSystemClock),
        .rUsePresetC  (rUsePresetC),
        .busBeat      (busBeat),
        .cle          (cle),
        .ale          (ale),
        .we           (we),
        .io           (io),
        .ceN          (ceN),
        .seqDone      (seqDone)
    );

endmodule

//--- hdl/caLatchIssuer.sv
`timescale 1ns/1ps
`include "nand_settings.svh"

module caLatchIssuer
(
    input  logic               iSystemClock,
    input  logic               rUsePresetC,
    input  nandBusPkg::caBeatT busBeat,
    output logic               cle,
    output logic               ale,
    output logic               we,
    output nandBusPkg::caByteT io,
    output nandCmdPkg::waySelT ceN,
    output logic               seqDone
);

    localparam int BusyWidth = $clog2(`BUSY_WAIT_CYCLES + 1);

    logic [BusyWidth-1:0] busyCount;
    logic                 busy;
    logic                 lastBeat;

    assign lastBeat = busBeat.valid && busBeat.last;

    always_ff @(posedge iSystemClock)
    begin
        if (rUsePresetC)
        begin
            cle     <= 1'b0;
            ale     <= 1'b0;
            we      <= 1'b0;
            ceN     <= '1;
            seqDone <= 1'b0;
        end
        else
        begin
            cle     <= busBeat.valid && !busBeat.isAddress;
            ale     <= busBeat.valid && busBeat.isAddress;
            we      <= busBeat.valid;                          // one strobe per beat
            ceN     <= busBeat.valid ? ~busBeat.way : '1;
            seqDone <= busy && (busyCount == '0);
        end
    end

    always_ff @(posedge iSystemClock)
    begin
        if (busBeat.valid)
            io <= busBeat.data;
    end

    // wait counts down from the cycle after the last beat
    always_ff @(posedge iSystemClock)
    begin
        if (rUsePresetC)
        begin
            busy      <= 1'b0;
            busyCount <= '0;
        end
        else if (lastBeat)
        begin
            busy      <= 1'b1;
            busyCount <= BusyWidth'(`BUSY_WAIT_CYCLES);
        end
        else if (busy)
        begin
            if (busyCount == '0)
                busy <= 1'b0;
            else
                busyCount <= busyCount - 1'b1;
        end
    end

endmodule

//--- hdl/caBusArbiter.sv
`timescale 1ns/1ps

module caBusArbiter
(
    input  logic               iSystemClock,
    input  logic               rUsePresetC,
    input  logic               readReq,
    input  logic               statusReq,
    input  nandBusPkg::caBeatT readBeat,
    input  nandBusPkg::caBeatT statusBeat,
    output logic               readGrant,
    output logic               statusGrant,
    output nandBusPkg::caBeatT busBeat,
    input  logic               seqDone,
    output logic               readDone,
    output logic               statusDone
);

    nandBusPkg::busOwnerT owner;
    nandBusPkg::busOwnerT lastServed;
    nandBusPkg::busOwnerT pick;
    logic                 locked;   // bus held until the last beat

    always_comb
    begin
        pick = nandBusPkg::ownerNone;
        if (readReq && statusReq)
            pick = (lastServed == nandBusPkg::ownerRead) ? nandBusPkg::ownerStatus
                                                         : nandBusPkg::ownerRead;
        else if (readReq)
            pick = nandBusPkg::ownerRead;
        else if (statusReq)
            pick = nandBusPkg::ownerStatus;
    end

    always_ff @(posedge iSystemClock)
    begin
        if (rUsePresetC)
        begin
            owner      <= nandBusPkg::ownerNone;
            lastServed <= nandBusPkg::ownerNone;
            locked     <= 1'b0;
        end
        else if (owner == nandBusPkg::ownerNone)
        begin
            if (pick != nandBusPkg::ownerNone)
            begin
                owner      <= pick;
                lastServed <= pick;
                locked     <= 1'b1;
            end
        end
        else
        begin
            if (busBeat.valid && busBeat.last)
                locked <= 1'b0;
            if (seqDone)
                owner <= nandBusPkg::ownerNone;   // owner kept through the busy wait
        end
    end

    assign readGrant   = locked && (owner == nandBusPkg::ownerRead);
    assign statusGrant = locked && (owner == nandBusPkg::ownerStatus);

    always_comb
    begin
        if (readGrant)
            busBeat = readBeat;
        else if (statusGrant)
            busBeat = statusBeat;
        else
            busBeat = '0;
    end

    assign readDone   = seqDone && (owner == nandBusPkg::ownerRead);
    assign statusDone = seqDone && (owner == nandBusPkg::ownerStatus);

endmodule

//--- hdl/statusResetSequencer.sv
`timescale 1ns/1ps
`include "nand_settings.svh"

module statusResetSequencer
(
    input  logic                iSystemClock,
    input  logic                rUsePresetC,
    input  nandCmdPkg::hostCmdT cmd,
    input  logic                cmdValid,
    output logic                idle,
    output logic                busReq,
    input  logic                busGrant,
    output nandBusPkg::caBeatT  beat,
    input  logic                ownerDone,
    output logic                opDone
);

    typedef enum logic [1:0] {
        srIdle,
        srIssue,
        srWaitDone
    } srStateT;

    srStateT            state;
    nandCmdPkg::waySelT targetWay;
    logic               isReset;
    logic               accept;

    assign accept = idle && cmdValid && (cmd.targetId == `TARGET_STATUS_RESET)
                    && (cmd.opcode[5:1] == 5'b00000);

    assign idle   = (state == srIdle);
    assign busReq = (state == srIssue);
    assign opDone = (state == srWaitDone) && ownerDone;

    always_ff @(posedge iSystemClock)
    begin
        if (rUsePresetC)
            state <= srIdle;
        else
            case (state)
                srIdle:     if (accept) state <= srIssue;
                srIssue:    if (busGrant) state <= srWaitDone;   // single beat
                srWaitDone: if (ownerDone) state <= srIdle;
                default:    state <= srIdle;
            endcase
    end

    always_ff @(posedge iSystemClock)
    begin
        if (accept)
        begin
            targetWay <= cmd.waySelect;
            isReset   <= cmd.opcode[0];
        end
    end

    always_comb
    begin
        beat = '0;
        if (busReq && busGrant)
        begin
            beat.valid = 1'b1;
            beat.last  = 1'b1;
            beat.way   = targetWay;
            beat.data  = isReset ? 8'hFF : 8'h70;
        end
    end

endmodule

//--- hdl/pageReadSequencer.sv
`timescale 1ns/1ps
`include "nand_settings.svh"

module pageReadSequencer
(
    input  logic                iSystemClock,
    input  logic                rUsePresetC,
    input  nandCmdPkg::hostCmdT cmd,
    input  logic                cmdValid,
    output logic                idle,
    output logic                busReq,
    input  logic                busGrant,
    output nandBusPkg::caBeatT  beat,
    input  logic                ownerDone,
    output logic                opDone
);

    typedef enum logic [3:0] {
        readIdle,
        readPreset,
        readPageSel,
        readCmd0,
        readAddr0,
        readAddr1,
        readAddr2,
        readAddr3,
        readAddr4,
        readConfirm,
        readWaitDone
    } readStateT;

    readStateT state;
    readStateT nextState;
    readStateT firstStep;

    nandCmdPkg::waySelT  targetWay;
    nandCmdPkg::colAddrT colAddr;
    nandCmdPkg::rowAddrT rowAddr;
    logic [2:0]          pageSelect;
    logic                slcMode;
    logic                multiPlane;
    logic                usePreset;

    logic                accept;
    logic                needPageSel;
    nandBusPkg::caByteT  stepByte;
    logic                stepIsAddress;

    assign accept      = idle && cmdValid && (cmd.targetId == `TARGET_PAGE_READ)
                         && (cmd.opcode[5:1] == 5'b00000);
    assign needPageSel = slcMode || (pageSelect != 3'b000);

    assign idle   = (state == readIdle);
    assign busReq = (state != readIdle) && (state != readWaitDone);
    assign opDone = (state == readWaitDone) && ownerDone;

    always_comb
    begin
        if (cmd.sourceId[4])
            firstStep = readPreset;
        else if (cmd.sourceId[3] || (cmd.sourceId[2:0] != 3'b000))
            firstStep = readPageSel;
        else
            firstStep = readCmd0;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            readIdle:     if (accept) nextState = firstStep;
            readPreset:   if (busGrant) nextState = needPageSel ? readPageSel : readCmd0;
            readPageSel:  if (busGrant) nextState = readCmd0;
            readCmd0:     if (busGrant) nextState = readAddr0;
            readAddr0:    if (busGrant) nextState = readAddr1;
            readAddr1:    if (busGrant) nextState = readAddr2;
            readAddr2:    if (busGrant) nextState = readAddr3;
            readAddr3:    if (busGrant) nextState = readAddr4;
            readAddr4:    if (busGrant) nextState = readConfirm;
            readConfirm:  if (busGrant) nextState = readWaitDone;
            readWaitDone: if (ownerDone) nextState = readIdle;
            default:      nextState = readIdle;
        endcase
    end

    always_ff @(posedge iSystemClock)
    begin
        if (rUsePresetC)
            state <= readIdle;
        else
            state <= nextState;
    end

    always_ff @(posedge iSystemClock)
    begin
        if (accept)
        begin
            targetWay  <= cmd.waySelect;
            colAddr    <= cmd.colAddress;
            rowAddr    <= cmd.rowAddress;
            pageSelect <= cmd.sourceId[2:0];
            slcMode    <= cmd.sourceId[3];
            usePreset  <= cmd.sourceId[4];
            multiPlane <= cmd.opcode[0];
        end
    end

    always_comb
    begin
        stepByte      = 8'h00;
        stepIsAddress = 1'b0;
        case (state)
            readPreset:  stepByte = slcMode ? 8'hC9 : 8'h26;   // SSR or calibrated read
            readPageSel: stepByte = (!usePreset && slcMode) ? 8'hA2 : {5'b00000, pageSelect};
            readAddr0:   {stepIsAddress, stepByte} = {1'b1, colAddr[7:0]};
            readAddr1:   {stepIsAddress, stepByte} = {1'b1, colAddr[15:8]};
            readAddr2:   {stepIsAddress, stepByte} = {1'b1, rowAddr[7:0]};
            readAddr3:   {stepIsAddress, stepByte} = {1'b1, rowAddr[15:8]};
            readAddr4:   {stepIsAddress, stepByte} = {1'b1, rowAddr[23:16]};
            readConfirm: stepByte = multiPlane ? 8'h32 : 8'h30;
            default:     stepByte = 8'h00;
        endcase
    end

    always_comb
    begin
        beat = '0;
        if (busReq && busGrant)
        begin
            beat.valid     = 1'b1;
            beat.isAddress = stepIsAddress;
            beat.last      = (state == readConfirm);
            beat.way       = targetWay;
            beat.data      = stepByte;
        end
    end

endmodule

//--- hdl/nandBusPkg.sv
package nandBusPkg;

    typedef logic [7:0] caByteT;

    typedef struct packed {
        logic                valid;
        logic                isAddress;   // ale byte when set, cle byte otherwise
        logic                last;        // final byte of a sequence
        nandCmdPkg::waySelT  way;
        caByteT              data;
    } caBeatT;

    typedef enum logic [1:0] {
        ownerNone,
        ownerRead,
        ownerStatus
    } busOwnerT;

endpackage

//--- hdl/nandCmdPkg.sv
`include "nand_settings.svh"

package nandCmdPkg;

    typedef logic [5:0]            opcodeT;
    typedef logic [4:0]            idT;
    typedef logic [15:0]           colAddrT;
    typedef logic [23:0]           rowAddrT;
    typedef logic [`NUM_WAYS-1:0]  waySelT;   // one-hot chip enable select

    // sourceId carries page select [2:0], pSLC/SSR [3] and use-preset [4] for a page read
    typedef struct packed {
        opcodeT   opcode;
        idT       targetId;
        idT       sourceId;
        waySelT   waySelect;
        colAddrT  colAddress;
        rowAddrT  rowAddress;
    } hostCmdT;

endpackage

//--- hdl/nand_settings.svh
`ifndef NAND_SETTINGS_SVH
`define NAND_SETTINGS_SVH

// chip enables on the channel
`define NUM_WAYS 4

// idle cycles between the last latched byte and completion
`define BUSY_WAIT_CYCLES 10

// target IDs decoded by the two sequencers
`define TARGET_PAGE_READ    5'b00101
`define TARGET_STATUS_RESET 5'b00110

`endif
